/* rtl/sifhPkg.sv */
package sifhPkg;

    //**************************************************************************
    // widths
    //**************************************************************************

    // timestamp width, full range 0..1023
    localparam int TS_W = 10;
    // histogram address width
    localparam int BIN_W = 6;
    // pixel index width, up to 16 pixels
    localparam int PIX_W = 4;

    // bins per pass, also the fine window width
    localparam int BIN_NUM = 1 << BIN_W;
    // half window, subtracted from the coarse centre
    localparam int WIN_HALF = BIN_NUM / 2;
    // highest window base that keeps the window inside the range
    localparam logic [TS_W-1:0] BASE_MAX = TS_W'((1 << TS_W) - BIN_NUM);

    //**************************************************************************
    // enums
    //**************************************************************************

    // which histogram pass a sample belongs to
    typedef enum logic {
        PASS_COARSE,
        PASS_FINE
    } passKind_t;

    // sorter FSM
    typedef enum logic [1:0] {
        SORT_COARSE,
        SORT_FINE,
        SORT_FLUSH
    } sorterState_t;

    //**************************************************************************
    // structs
    //**************************************************************************

    // sorter to lanes, 13 bits
    typedef struct packed {
        logic              valid;
        passKind_t         pass;
        logic [TS_W-1:0]   timestamp;
        logic              firstOfPass;
    } laneSample_t;

    // one drained result, 14 bits
    typedef struct packed {
        logic [PIX_W-1:0]  pixel;
        logic [TS_W-1:0]   peak;
    } peakResult_t;

endpackage

/* rtl/sampleSorter.sv */
module sampleSorter #(
    parameter int PIXEL_NUM = 8,
    parameter int ACQ_NUM   = 24
) (
    input  logic                      clk,
    input  logic                      combin_res,
    input  logic                      tsValid,
    input  logic [sifhPkg::TS_W-1:0]  tsData,
    output sifhPkg::laneSample_t      laneSample,
    output logic [PIXEL_NUM-1:0]      laneSel,
    output logic                      frameEnd
);
    import sifhPkg::*;

    // acquisition counter width, never zero
    localparam int ACQ_W = $clog2(ACQ_NUM + 1);

    sorterState_t     state;
    logic [PIX_W-1:0] pixCnt;
    logic [ACQ_W-1:0] acqCnt;
    logic             flushCnt;

    // registered sample fields
    logic             smpValid;
    passKind_t        smpPass;
    logic [TS_W-1:0]  smpTs;
    logic             smpFirst;

    logic             lastPix;
    logic             lastAcq;
    logic             passEnd;
    passKind_t        passNow;

    //**************************************************************************
    // pass bookkeeping
    //**************************************************************************

    assign lastPix = pixCnt == PIX_W'(PIXEL_NUM - 1);
    assign lastAcq = acqCnt == ACQ_W'(ACQ_NUM - 1);
    // last sample of a pass, PIXEL_NUM x ACQ_NUM samples
    assign passEnd = tsValid && lastPix && lastAcq;
    // samples seen during the flush already belong to the next coarse pass
    assign passNow = (state == SORT_FINE) ? PASS_FINE : PASS_COARSE;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state    <= SORT_COARSE;
            pixCnt   <= '0;
            acqCnt   <= '0;
            flushCnt <= 1'b0;
            frameEnd <= 1'b0;
            smpValid <= 1'b0;
            laneSel  <= '0;
        end else begin
            frameEnd <= 1'b0;
            smpValid <= tsValid;
            if (tsValid) begin
                laneSel <= PIXEL_NUM'(1) << pixCnt;
                // pixel order wraps every strobe group
                pixCnt  <= lastPix ? '0 : pixCnt + 1'b1;
                if (lastPix) begin
                    acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                end
            end
            case (state)
                SORT_COARSE: begin
                    if (passEnd) begin
                        state <= SORT_FINE;
                    end
                end
                SORT_FINE: begin
                    if (passEnd) begin
                        state    <= SORT_FLUSH;
                        flushCnt <= 1'b0;
                    end
                end
                SORT_FLUSH: begin
                    // two cycles so the last fine sample reaches the lane max
                    flushCnt <= 1'b1;
                    if (flushCnt) begin
                        state    <= SORT_COARSE;
                        frameEnd <= 1'b1;
                    end
                end
                default: begin
                    state <= SORT_COARSE;
                end
            endcase
        end
    end

    // payload, captured with every strobe
    always_ff @(posedge clk) begin
        if (tsValid) begin
            smpPass  <= passNow;
            smpTs    <= tsData;
            // first sample of this pixel in the pass
            smpFirst <= acqCnt == '0;
        end
    end

    assign laneSample = '{valid: smpValid, pass: smpPass, timestamp: smpTs,
                          firstOfPass: smpFirst};

endmodule

/* rtl/pixelHistLane.sv */
module pixelHistLane #(
    parameter int COUNT_W = 6
) (
    input  logic                      clk,
    input  logic                      combin_res,
    input  sifhPkg::laneSample_t      laneSample,
    input  logic                      sel,
    output logic [sifhPkg::TS_W-1:0]  lanePeak
);
    import sifhPkg::*;

    // histogram memory and per-bin valid flags
    logic [COUNT_W-1:0] binCount [BIN_NUM];
    logic [BIN_NUM-1:0] binValid;

    // running max and peak bin, one set per pass
    logic [COUNT_W-1:0] runMax [2];
    logic [BIN_W-1:0]   peakBin [2];
    // coarse peak that the fine window is centred on
    logic [BIN_W-1:0]   winBin;

    // stage 0, address and count
    logic               act;
    logic               fineFirst;
    logic [BIN_W-1:0]   centreBin;
    logic [TS_W-1:0]    base;
    logic [TS_W-1:0]    offset;
    logic [BIN_W-1:0]   addr;
    logic               hit;
    logic [COUNT_W-1:0] newCount;

    // stage 1, peak tracking
    logic               s1Valid;
    passKind_t          s1Pass;
    logic               s1First;
    logic               s1Hit;
    logic [BIN_W-1:0]   s1Addr;
    logic [COUNT_W-1:0] s1Count;
    logic [COUNT_W-1:0] curMax;
    logic               takePeak;
    logic               clearPeak;
    logic [BIN_W-1:0]   coarseNext;

    // window base from a coarse bin, clamped to 0..BASE_MAX
    function automatic logic [TS_W-1:0] winBase(input logic [BIN_W-1:0] bin);
        logic [TS_W-1:0] centre;
        centre = TS_W'(bin) << (TS_W - BIN_W);
        if (centre < TS_W'(WIN_HALF)) begin
            return '0;
        end else if (centre - TS_W'(WIN_HALF) > BASE_MAX) begin
            return BASE_MAX;
        end
        return centre - TS_W'(WIN_HALF);
    endfunction

    //**************************************************************************
    // stage 1 compare
    //**************************************************************************

    always_comb begin
        // first sample restarts the max of its pass
        curMax    = s1First ? '0 : runMax[s1Pass];
        // strictly greater, earliest bin keeps a tie
        takePeak  = s1Valid && s1Hit && (s1Count > curMax);
        clearPeak = s1Valid && s1First && !takePeak;
        // coarse peak as it stands after this cycle
        coarseNext = peakBin[PASS_COARSE];
        if (s1Pass == PASS_COARSE) begin
            if (takePeak) begin
                coarseNext = s1Addr;
            end else if (clearPeak) begin
                coarseNext = '0;
            end
        end
    end

    //**************************************************************************
    // stage 0 address
    //**************************************************************************

    always_comb begin
        act       = laneSample.valid && sel;
        fineFirst = laneSample.firstOfPass && (laneSample.pass == PASS_FINE);
        // bypass so a just-finished coarse peak is seen
        centreBin = fineFirst ? coarseNext : winBin;
        base      = winBase(centreBin);
        offset    = laneSample.timestamp - base;
        if (laneSample.pass == PASS_COARSE) begin
            // top bits of the timestamp
            addr = laneSample.timestamp[TS_W-1 -: BIN_W];
            hit  = 1'b1;
        end else begin
            addr = offset[BIN_W-1:0];
            // outside the window is dropped
            hit  = (laneSample.timestamp >= base) && (offset < TS_W'(BIN_NUM));
        end
        // stale bins count as empty
        if (binValid[addr] && !laneSample.firstOfPass) begin
            newCount = binCount[addr] + 1'b1;
        end else begin
            newCount = COUNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (act && hit) begin
            binCount[addr] <= newCount;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            s1Valid  <= 1'b0;
            runMax   <= '{default: '0};
            peakBin  <= '{default: '0};
            winBin   <= '0;
        end else begin
            s1Valid <= act;
            if (act) begin
                binValid <= (laneSample.firstOfPass ? '0 : binValid)
                          | (hit ? BIN_NUM'(1) << addr : '0);
            end
            if (act && fineFirst) begin
                winBin <= coarseNext;
            end
            if (takePeak) begin
                runMax[s1Pass]  <= s1Count;
                peakBin[s1Pass] <= s1Addr;
            end else if (clearPeak) begin
                runMax[s1Pass]  <= '0;
                peakBin[s1Pass] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        s1Pass  <= laneSample.pass;
        s1First <= laneSample.firstOfPass;
        s1Hit   <= hit;
        s1Addr  <= addr;
        s1Count <= newCount;
    end

    // held until this pixel's next fine pass starts
    assign lanePeak = winBase(winBin) + TS_W'(peakBin[PASS_FINE]);

endmodule

/* rtl/peakCollector.sv */
module peakCollector #(
    parameter int PIXEL_NUM = 8
) (
    input  logic                                      clk,
    input  logic                                      combin_res,
    input  logic                                      frameEnd,
    input  logic [PIXEL_NUM-1:0][sifhPkg::TS_W-1:0]   lanePeak,
    output logic                                      resultValid,
    output sifhPkg::peakResult_t                      result
);
    import sifhPkg::*;

    // snapshot of all lanes, pixel 0 in the low slot
    logic [PIXEL_NUM-1:0][TS_W-1:0] peakBuf;
    logic                           draining;
    logic [PIX_W-1:0]               drainCnt;
    logic                           lastDrain;

    assign lastDrain = drainCnt == PIX_W'(PIXEL_NUM - 1);

    //**************************************************************************
    // drain control
    //**************************************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            draining <= 1'b0;
            drainCnt <= '0;
        end else begin
            if (frameEnd) begin
                // start from pixel 0
                draining <= 1'b1;
                drainCnt <= '0;
            end else if (draining) begin
                drainCnt <= drainCnt + 1'b1;
                // stop after the last pixel
                if (lastDrain) begin
                    draining <= 1'b0;
                end
            end
        end
    end

    //**************************************************************************
    // snapshot and shift
    //**************************************************************************

    always_ff @(posedge clk) begin
        if (frameEnd) begin
            peakBuf <= lanePeak;
        end else if (draining) begin
            // next pixel moves into slot 0
            peakBuf <= peakBuf >> TS_W;
        end
    end

    // one result per cycle while draining
    always_comb begin
        resultValid  = draining;
        result.pixel = drainCnt;
        result.peak  = peakBuf[0];
    end

endmodule

/* rtl/sifhPeakFinder.sv */
module sifhPeakFinder #(
    parameter int PIXEL_NUM = 8,
    parameter int ACQ_NUM   = 24,
    parameter int COUNT_W   = 6
) (
    input  logic                      clk,
    input  logic                      combin_res,
    input  logic                      tsValid,
    input  logic [sifhPkg::TS_W-1:0]  tsData,
    output logic                      resultValid,
    output sifhPkg::peakResult_t      result
);
    import sifhPkg::*;

    // sorter broadcast
    laneSample_t                    laneSample;
    logic [PIXEL_NUM-1:0]           laneSel;
    logic                           frameEnd;
    // finished peak per pixel
    logic [PIXEL_NUM-1:0][TS_W-1:0] lanePeak;

    // pixel index must fit the result field
    if (PIXEL_NUM < 1 || PIXEL_NUM > (1 << PIX_W)) begin : g_badPixelNum
        $error("PIXEL_NUM must be between 1 and %0d", 1 << PIX_W);
    end

    //**************************************************************************
    // sorter, lanes, collector
    //**************************************************************************

    sampleSorter #(
        .PIXEL_NUM (PIXEL_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) i_sorter (
        .clk        (clk),
        .combin_res (combin_res),
        .tsValid    (tsValid),
        .tsData     (tsData),
        .laneSample (laneSample),
        .laneSel    (laneSel),
        .frameEnd   (frameEnd)
    );

    // one histogram lane per pixel
    for (genvar p = 0; p < PIXEL_NUM; p++) begin : g_lane
        pixelHistLane #(
            .COUNT_W (COUNT_W)
        ) i_lane (
            .clk        (clk),
            .combin_res (combin_res),
            .laneSample (laneSample),
            .sel        (laneSel[p]),
            .lanePeak   (lanePeak[p])
        );
    end

    peakCollector #(
        .PIXEL_NUM (PIXEL_NUM)
    ) i_collector (
        .clk         (clk),
        .combin_res  (combin_res),
        .frameEnd    (frameEnd),
        .lanePeak    (lanePeak),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

/* dv/sifhPeakFinder_chk.sv */
module sifhPeakFinderChk #(
    parameter int PIXEL_NUM = 8
) (
    input logic                 clk,
    input logic                 combin_res,
    input sifhPkg::laneSample_t laneSample,
    input logic [PIXEL_NUM-1:0] laneSel,
    input logic                 resultValid,
    input sifhPkg::peakResult_t result
);
    timeunit 1ns;
    timeprecision 1ps;
    import sifhPkg::*;

    // cycles of resultValid already seen in the current run
    int runLen;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            runLen <= 0;
        end else begin
            runLen <= resultValid ? runLen + 1 : 0;
        end
    end

    // exactly one lane per sample
    laneSelOneHot: assert property (@(posedge clk) disable iff (!combin_res)
        laneSample.valid |-> $onehot(laneSel))
        else $error("laneSel is not one-hot for a valid sample");

    // a drain is at most one strobe per pixel
    drainLength: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |-> runLen < PIXEL_NUM)
        else $error("resultValid held longer than PIXEL_NUM cycles");

    drainStart: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(resultValid) |-> result.pixel == '0)
        else $error("drain did not start at pixel 0");

    drainStep: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid && $past(resultValid) |-> result.pixel == $past(result.pixel) + 1'b1)
        else $error("pixel index did not step by one during the drain");

endmodule

// sorter and collector outputs as wired in the top level
bind sifhPeakFinder sifhPeakFinderChk #(
    .PIXEL_NUM (PIXEL_NUM)
) i_chk (
    .clk         (clk),
    .combin_res  (combin_res),
    .laneSample  (laneSample),
    .laneSel     (laneSel),
    .resultValid (resultValid),
    .result      (result)
);

/* dv/sifhPeakFinderTb.sv */
module sifhPeakFinderTb;
    timeunit 1ns;
    timeprecision 1ps;
    import sifhPkg::*;

    localparam int PIXEL_NUM = 8;
    localparam int ACQ_NUM   = 24;
    localparam int COUNT_W   = 6;
    // samples in one pass over all pixels
    localparam int PASS_LEN  = PIXEL_NUM * ACQ_NUM;
    localparam int BINS      = 1 << BIN_W;
    localparam int TS_RANGE  = 1 << TS_W;
    // frame kinds, by where the cluster centres sit
    localparam int MODE_MID  = 0;
    localparam int MODE_LOW  = 1;
    localparam int MODE_HIGH = 2;
    // seven full frames, one cut by reset, one after it
    localparam int FRAME_NUM = 9;
    localparam int FRAME_CYC = 2 * PIXEL_NUM * ACQ_NUM + PIXEL_NUM + 8;
    localparam int WATCH_NS  = FRAME_NUM * FRAME_CYC * 10 * 2;

    logic        clk;
    logic        combin_res;
    logic        tsValid;
    logic [TS_W-1:0] tsData;
    logic        resultValid;
    peakResult_t result;

    integer      seed;
    // per frame samples, [pixel][acquisition]
    int          coarseTs [PIXEL_NUM][ACQ_NUM];
    int          fineTs [PIXEL_NUM][ACQ_NUM];
    peakResult_t expQ [$];
    string       nameQ [$];
    peakResult_t expRes;
    string       expName;
    int          pushed;
    int          matched;

    sifhPeakFinder #(
        .PIXEL_NUM (PIXEL_NUM),
        .ACQ_NUM   (ACQ_NUM),
        .COUNT_W   (COUNT_W)
    ) i_dut (
        .clk         (clk),
        .combin_res  (combin_res),
        .tsValid     (tsValid),
        .tsData      (tsData),
        .resultValid (resultValid),
        .result      (result)
    );

    always #5 clk = ~clk;

    //**************************************************************************
    // random helpers
    //**************************************************************************

    function automatic int urand(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // cluster around the centre, or an outlier anywhere in range
    function automatic int drawTs(input int centre, input int outPct);
        int ts;
        if (urand(100) < outPct) begin
            return urand(TS_RANGE);
        end
        ts = centre + urand(13) - 6;
        if (ts < 0) begin
            ts = 0;
        end else if (ts > TS_RANGE - 1) begin
            ts = TS_RANGE - 1;
        end
        return ts;
    endfunction

    //**************************************************************************
    // reference model
    //**************************************************************************

    // coarse peak, clamped window, then first bin to reach the top count
    function automatic logic [TS_W-1:0] expectPeak(input int pix);
        int cnt [BINS];
        int maxCnt;
        int coarseBin;
        int fineBin;
        int base;
        int off;
        foreach (cnt[i]) begin
            cnt[i] = 0;
        end
        maxCnt    = 0;
        coarseBin = 0;
        for (int a = 0; a < ACQ_NUM; a++) begin
            off = coarseTs[pix][a] >> (TS_W - BIN_W);
            cnt[off]++;
            if (cnt[off] > maxCnt) begin
                maxCnt    = cnt[off];
                coarseBin = off;
            end
        end
        // coarse bin back to timestamp units, minus half a window
        base = coarseBin * (1 << (TS_W - BIN_W)) - BINS / 2;
        if (base < 0) begin
            base = 0;
        end else if (base > TS_RANGE - BINS) begin
            base = TS_RANGE - BINS;
        end
        foreach (cnt[i]) begin
            cnt[i] = 0;
        end
        maxCnt  = 0;
        fineBin = 0;
        for (int a = 0; a < ACQ_NUM; a++) begin
            off = fineTs[pix][a] - base;
            // only inside the window
            if (off >= 0 && off < BINS) begin
                cnt[off]++;
                if (cnt[off] > maxCnt) begin
                    maxCnt  = cnt[off];
                    fineBin = off;
                end
            end
        end
        return TS_W'(base + fineBin);
    endfunction

    //**************************************************************************
    // compare tasks
    //**************************************************************************

    task automatic checkPixel(input string name, input peakResult_t exp,
                              input peakResult_t act);
        if (act.pixel !== exp.pixel) begin
            $display("[FAIL] %s pixel expected %0d actual %0d", name, exp.pixel, act.pixel);
            $display("** FAIL **");
            $fatal(1, "pixel index mismatch");
        end
    endtask

    task automatic checkPeak(input string name, input peakResult_t exp,
                             input peakResult_t act);
        if (act.peak !== exp.peak) begin
            $display("[FAIL] %s peak expected %0d actual %0d", name, exp.peak, act.peak);
            $display("** FAIL **");
            $fatal(1, "peak value mismatch");
        end
    endtask

    //**************************************************************************
    // stimulus
    //**************************************************************************

    task automatic buildFrame(input int mode, input int fineOutPct);
        int centre;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            case (mode)
                MODE_LOW:  centre = urand(40);
                MODE_HIGH: centre = TS_RANGE - 1 - urand(40);
                default:   centre = 200 + urand(600);
            endcase
            for (int a = 0; a < ACQ_NUM; a++) begin
                // few coarse outliers, fine rate set per frame
                coarseTs[p][a] = drawTs(centre, 5);
                fineTs[p][a]   = drawTs(centre, fineOutPct);
            end
        end
    endtask

    task automatic queueExpected(input string name);
        peakResult_t res;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            res.pixel = PIX_W'(p);
            res.peak  = expectPeak(p);
            expQ.push_back(res);
            nameQ.push_back($sformatf("%s px%0d", name, p));
            pushed++;
        end
    endtask

    // optional idle cycle before the strobe
    task automatic sendSample(input int ts, input bit gaps);
        if (gaps && urand(4) == 0) begin
            @(negedge clk);
            tsValid <= 1'b0;
        end
        @(negedge clk);
        tsValid <= 1'b1;
        tsData  <= TS_W'(ts);
    endtask

    // pixel order inside each acquisition
    task automatic sendPass(input bit fine, input int count, input bit gaps);
        int sent;
        sent = 0;
        for (int a = 0; a < ACQ_NUM; a++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                if (sent < count) begin
                    sendSample(fine ? fineTs[p][a] : coarseTs[p][a], gaps);
                    sent++;
                end
            end
        end
    endtask

    task automatic runFrame(input string name, input int mode, input int fineOutPct,
                            input bit gaps);
        buildFrame(mode, fineOutPct);
        queueExpected(name);
        sendPass(1'b0, PASS_LEN, gaps);
        sendPass(1'b1, PASS_LEN, gaps);
    endtask

    // stop the stream and let every queued result come out
    task automatic waitDrain();
        int waited;
        @(negedge clk);
        tsValid <= 1'b0;
        waited = 0;
        // give up after a frame's worth of cycles
        while (expQ.size() != 0 && waited < FRAME_CYC) begin
            @(negedge clk);
            waited++;
        end
        repeat (PIXEL_NUM + 4) @(negedge clk);
    endtask

    //**************************************************************************
    // result monitor
    //**************************************************************************

    // outputs come from registers, stable at the falling edge
    always @(negedge clk) begin
        if (resultValid) begin
            if (expQ.size() == 0) begin
                $display("a result came out while no frame result was pending");
                $display("** FAIL **");
                $fatal(1, "unexpected result");
            end else begin
                expRes  = expQ.pop_front();
                expName = nameQ.pop_front();
                checkPixel(expName, expRes, result);
                checkPeak(expName, expRes, result);
                matched++;
            end
        end
    end

    initial begin
        #(WATCH_NS);
        $display("simulation hung, results did not arrive in time");
        $display("** FAIL **");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        seed       = 32'hbaeea28f;
        pushed     = 0;
        matched    = 0;
        clk        = 1'b0;
        combin_res = 1'b0;
        tsValid    = 1'b0;
        tsData     = '0;
        repeat (4) @(negedge clk);
        combin_res <= 1'b1;
        repeat (2) @(negedge clk);
        runFrame("midRange", MODE_MID, 0, 1'b1);
        runFrame("lowClamp", MODE_LOW, 5, 1'b1);
        runFrame("highClamp", MODE_HIGH, 5, 1'b1);
        // many fine outliers, mostly outside the window
        runFrame("outliers", MODE_MID, 40, 1'b1);
        // no idle cycles, next frame streams during the drain
        runFrame("backToBack0", MODE_MID, 10, 1'b0);
        runFrame("backToBack1", MODE_LOW, 10, 1'b0);
        runFrame("backToBack2", MODE_HIGH, 10, 1'b0);
        waitDrain();
        // partial frame, cut by reset half way through the fine pass
        buildFrame(MODE_MID, 10);
        sendPass(1'b0, PASS_LEN, 1'b0);
        sendPass(1'b1, PASS_LEN / 2, 1'b0);
        @(negedge clk);
        tsValid    <= 1'b0;
        combin_res <= 1'b0;
        repeat (4) @(negedge clk);
        combin_res <= 1'b1;
        @(negedge clk);
        runFrame("afterReset", MODE_MID, 10, 1'b1);
        waitDrain();
        if (matched == pushed) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("only %0d of %0d results were checked", matched, pushed);
            $display("** FAIL **");
            $fatal(1, "result count mismatch");
        end
    end

endmodule

/* sifhPeakFinder.f */
rtl/sifhPkg.sv
rtl/sampleSorter.sv
rtl/pixelHistLane.sv
rtl/peakCollector.sv
rtl/sifhPeakFinder.sv
dv/sifhPeakFinder_chk.sv
dv/sifhPeakFinderTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := sifhPeakFinderTb
FILELIST   := sifhPeakFinder.f
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert --timescale 1ns/1ps
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q -F '** PASS **' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
